/* source/bank_sram.sv */
/*
 * Bank memory, one port or two, read data one cycle after the request.
 * A port either writes or reads in a cycle. Contents clear to zero on reset.
 */
`timescale 1ns/1ps

module bank_sram import rf_pkg::*; #(
    parameter bit DualPort = 1'b0
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Port index 1 only exists in the dual-port build
    input  logic       [DualPort:0] req_i,
    input  logic       [DualPort:0] we_i,
    input  bank_addr_t [DualPort:0] addr_i,
    input  warp_data_t [DualPort:0] wdata_i,
    input  be_t        [DualPort:0] be_i,
    output warp_data_t [DualPort:0] rdata_o
);

    localparam int unsigned NumPorts = DualPort ? 2 : 1;

    warp_data_t mem_q [BankRegs];

    // Byte-enabled writes
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < BankRegs; w++) begin
                mem_q[w] <= '0;
            end
        end else begin
            for (int p = 0; p < NumPorts; p++) begin
                if (req_i[p] && we_i[p]) begin
                    for (int l = 0; l < WarpWidth; l++) begin
                        for (int k = 0; k < BytesPerLane; k++) begin
                            // Byte k of lane l
                            if (be_i[p][l*BytesPerLane + k]) begin
                                mem_q[addr_i[p]][l][k*8 +: 8] <= wdata_i[p][l][k*8 +: 8];
                            end
                        end
                    end
                end
            end
        end
    end

    // Registered read, holds between reads
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NumPorts; p++) begin
            if (req_i[p] && !we_i[p]) begin
                rdata_o[p] <= mem_q[addr_i[p]];
            end
        end
    end

endmodule

/* source/operand_collector.sv */
/*
 * In-order operand collector, QueueDepth slots. Bank results and a fresh
 * allocation are seen in the same cycle they arrive.
 */
`timescale 1ns/1ps

module operand_collector import rf_pkg::*, operand_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  collector_alloc_t            alloc_i,
    // Bank results
    input  logic         [NumBanks-1:0] bank_valid_i,
    input  rf_read_tag_t [NumBanks-1:0] bank_tag_i,
    input  warp_data_t   [NumBanks-1:0] bank_data_i,
    output logic                        full_o,
    output operand_pair_t               pair_o
);

    // op[0] is operand A, op[1] operand B
    typedef struct packed {
        instr_id_t        instr_id;
        warp_data_t [1:0] op;
    } slot_t;

    slot_t                           slot_d [QueueDepth];
    slot_t                           slot_q [QueueDepth];
    logic      [QueueDepth-1:0]      busy_d;
    logic      [QueueDepth-1:0]      busy_q;
    logic      [QueueDepth-1:0][1:0] filled_d;
    logic      [QueueDepth-1:0][1:0] filled_q;
    slot_idx_t                       head_d;
    slot_idx_t                       head_q;
    operand_pair_t                   pair_d;
    operand_pair_t                   pair_q;

    // Sign-extend the immediate and copy it to every lane
    function automatic warp_data_t imm_broadcast(operand_spec_t spec);
        data_t lane;
        lane = data_t'($signed(spec.word.imm));
        return {WarpWidth{lane}};
    endfunction

    // ####################################################################
    // Slot update and pop

    always_comb begin
        slot_d   = slot_q;
        busy_d   = busy_q;
        filled_d = filled_q;
        head_d   = head_q;
        pair_d   = '0;

        // New slot, immediates filled right away
        if (alloc_i.req.valid) begin
            busy_d[alloc_i.slot]          = 1'b1;
            filled_d[alloc_i.slot]        = {alloc_i.req.src_b.is_imm, alloc_i.req.src_a.is_imm};
            slot_d[alloc_i.slot].instr_id = alloc_i.req.instr_id;
            // Register sources get overwritten by their bank result
            slot_d[alloc_i.slot].op[0]    = imm_broadcast(alloc_i.req.src_a);
            slot_d[alloc_i.slot].op[1]    = imm_broadcast(alloc_i.req.src_b);
        end

        // Both banks may return in one cycle
        for (int b = 0; b < NumBanks; b++) begin
            if (bank_valid_i[b]) begin
                slot_d[bank_tag_i[b].slot].op[bank_tag_i[b].src_b]   = bank_data_i[b];
                filled_d[bank_tag_i[b].slot][bank_tag_i[b].src_b] = 1'b1;
            end
        end

        // Head complete, hand it out and free it
        if (busy_d[head_q] && filled_d[head_q] == 2'b11) begin
            pair_d.valid    = 1'b1;
            pair_d.instr_id = slot_d[head_q].instr_id;
            pair_d.op_a     = slot_d[head_q].op[0];
            pair_d.op_b     = slot_d[head_q].op[1];
            busy_d[head_q]  = 1'b0;
            head_d          = head_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q   <= '0;
            filled_q <= '0;
            head_q   <= '0;
            pair_q   <= '0;
        end else begin
            busy_q   <= busy_d;
            filled_q <= filled_d;
            head_q   <= head_d;
            pair_q   <= pair_d;
        end
    end

    // Slot payload
    always_ff @(posedge clk_i) begin
        slot_q <= slot_d;
    end

    // Every slot taken
    assign full_o = &busy_q;
    assign pair_o = pair_q;

endmodule

/* source/operand_pkg.sv */
/*
 * Operand request and result types. QueueDepth must be a power of two,
 * slot pointers wrap without a compare.
 */
package operand_pkg;

    import rf_pkg::*;

    localparam int unsigned QueueDepth   = 4;
    localparam int unsigned InstrIdWidth = 4;
    localparam int unsigned ImmWidth     = 16;

    typedef logic [$clog2(QueueDepth)-1:0] slot_idx_t;
    typedef logic [InstrIdWidth-1:0]       instr_id_t;

    // Source word, read either as a register index or a signed immediate
    typedef union packed {
        struct packed {
            logic [ImmWidth-RegAddrWidth-1:0] pad;
            reg_addr_t                        idx;
        } rf;
        logic signed [ImmWidth-1:0] imm;
    } operand_word_t;

    // is_imm picks the reading of the word
    typedef struct packed {
        logic          is_imm;
        operand_word_t word;
    } operand_spec_t;

    // Where a bank result lands in the collector
    typedef struct packed {
        slot_idx_t slot;
        logic      src_b;
    } rf_read_tag_t;

    typedef struct packed {
        logic          valid;
        instr_id_t     instr_id;
        operand_spec_t src_a;
        operand_spec_t src_b;
    } operand_req_t;

    // Accepted request bound to its collector slot
    typedef struct packed {
        operand_req_t req;
        slot_idx_t    slot;
    } collector_alloc_t;

    typedef struct packed {
        logic       valid;
        instr_id_t  instr_id;
        warp_data_t op_a;
        warp_data_t op_b;
    } operand_pair_t;

endpackage

/* source/operand_request_router.sv */
/*
 * Turns operand requests into per-bank reads. A same-bank pair or a read
 * refused by a bank stalls new requests until it has been issued.
 */
`timescale 1ns/1ps

module operand_request_router import rf_pkg::*, operand_pkg::*; #(
    parameter bit DualPort = 1'b0
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  operand_req_t                req_i,
    output logic                        req_ready_o,
    input  rf_write_t                   write_i,
    output logic                        write_ready_o,
    // Collector side
    input  logic                        collector_full_i,
    output collector_alloc_t            alloc_o,
    // Bank side
    output rf_write_t    [NumBanks-1:0] bank_write_o,
    output logic         [NumBanks-1:0] bank_read_valid_o,
    input  logic         [NumBanks-1:0] bank_read_ready_i,
    output bank_addr_t   [NumBanks-1:0] bank_read_addr_o,
    output rf_read_tag_t [NumBanks-1:0] bank_read_tag_o
);

    typedef struct packed {
        logic         valid;
        logic         bank;
        bank_addr_t   addr;
        rf_read_tag_t tag;
    } bank_read_t;

    bank_read_t                read_a;
    bank_read_t                read_b;
    bank_read_t                pend_d;
    bank_read_t                pend_q;
    bank_read_t [NumBanks-1:0] issue;
    bank_read_t [NumBanks-1:0] retry_d;
    bank_read_t [NumBanks-1:0] retry_q;
    slot_idx_t                 tail_q;
    logic                      req_accept;
    logic                      conflict;
    logic                      retry_busy;
    logic                      pend_issued;

    // Register source to bank read, immediates issue nothing
    function automatic bank_read_t decode_src(operand_spec_t spec, logic valid,
                                              slot_idx_t slot, logic src_b);
        bank_read_t rd;
        rd.valid = valid & ~spec.is_imm;
        rd.bank  = spec.word.rf.idx[0];
        rd.addr  = spec.word.rf.idx[RegAddrWidth-1:1];
        rd.tag   = '{slot: slot, src_b: src_b};
        return rd;
    endfunction

    always_comb begin
        retry_busy = 1'b0;
        for (int b = 0; b < NumBanks; b++) begin
            retry_busy |= retry_q[b].valid;
        end
    end

    // Stall while the collector is full or older reads are waiting
    assign req_ready_o = ~collector_full_i & ~pend_q.valid & ~retry_busy;
    assign req_accept  = req_i.valid & req_ready_o;

    assign read_a   = decode_src(req_i.src_a, req_accept, tail_q, 1'b0);
    assign read_b   = decode_src(req_i.src_b, req_accept, tail_q, 1'b1);
    assign conflict = read_a.valid & read_b.valid & (read_a.bank == read_b.bank);

    // ####################################################################
    // Read issue per bank

    // Oldest first: refused read, then the held B read, then new reads
    always_comb begin
        for (int b = 0; b < NumBanks; b++) begin
            issue[b] = '0;
            if (retry_q[b].valid) begin
                issue[b] = retry_q[b];
            end else if (pend_q.valid && pend_q.bank == b) begin
                issue[b] = pend_q;
            end else if (read_a.valid && read_a.bank == b) begin
                issue[b] = read_a;
            end else if (read_b.valid && read_b.bank == b) begin
                issue[b] = read_b;
            end
            // Dual-port banks never refuse
            retry_d[b]       = issue[b];
            retry_d[b].valid = issue[b].valid & ~bank_read_ready_i[b] & ~DualPort;
        end
    end

    assign pend_issued = pend_q.valid & ~retry_q[pend_q.bank].valid;

    always_comb begin
        pend_d = pend_q;
        if (conflict) begin
            // Operand A went out, B waits a cycle
            pend_d = read_b;
        end else if (pend_issued) begin
            pend_d.valid = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_q  <= '0;
            retry_q <= '0;
            tail_q  <= '0;
        end else begin
            pend_q  <= pend_d;
            retry_q <= retry_d;
            if (req_accept) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    // ####################################################################
    // Outputs

    for (genvar b = 0; b < NumBanks; b++) begin : gen_bank_ports
        assign bank_read_valid_o[b] = issue[b].valid;
        assign bank_read_addr_o[b]  = issue[b].addr;
        assign bank_read_tag_o[b]   = issue[b].tag;

        // Write goes to the bank named by addr bit 0
        always_comb begin
            bank_write_o[b]       = write_i;
            bank_write_o[b].valid = write_i.valid & (write_i.addr[0] == b);
        end
    end

    // Both banks take a write every cycle
    assign write_ready_o = 1'b1;

    always_comb begin
        alloc_o           = '{req: req_i, slot: tail_q};
        alloc_o.req.valid = req_accept;
    end

endmodule

/* source/regfile_top.sv */
/*
 * Operand read stage top. Pairs leave in request order with variable
 * latency and no back-pressure on pair_o.
 */
`timescale 1ns/1ps

module regfile_top import rf_pkg::*, operand_pkg::*; #(
    parameter bit DualPort = 1'b0
) (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  rf_write_t     write_i,
    output logic          write_ready_o,
    input  operand_req_t  req_i,
    output logic          req_ready_o,
    output operand_pair_t pair_o
);

    collector_alloc_t            alloc;
    logic                        collector_full;
    // Router to banks
    rf_write_t    [NumBanks-1:0] bank_write;
    logic         [NumBanks-1:0] bank_read_valid;
    logic         [NumBanks-1:0] bank_read_ready;
    bank_addr_t   [NumBanks-1:0] bank_read_addr;
    rf_read_tag_t [NumBanks-1:0] bank_read_tag;
    // Banks to collector
    logic         [NumBanks-1:0] bank_rvalid;
    rf_read_tag_t [NumBanks-1:0] bank_rtag;
    warp_data_t   [NumBanks-1:0] bank_rdata;

    operand_request_router #(
        .DualPort(DualPort)
    ) u_router (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .req_i            (req_i),
        .req_ready_o      (req_ready_o),
        .write_i          (write_i),
        .write_ready_o    (write_ready_o),
        .collector_full_i (collector_full),
        .alloc_o          (alloc),
        .bank_write_o     (bank_write),
        .bank_read_valid_o(bank_read_valid),
        .bank_read_ready_i(bank_read_ready),
        .bank_read_addr_o (bank_read_addr),
        .bank_read_tag_o  (bank_read_tag)
    );

    // Even registers
    register_file_bank #(
        .DualPort(DualPort)
    ) u_bank_even (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .write_valid_i(bank_write[0].valid),
        .write_mask_i (bank_write[0].mask),
        .write_addr_i (bank_write[0].addr[RegAddrWidth-1:1]),
        .write_data_i (bank_write[0].data),
        .write_ready_o(),
        .read_valid_i (bank_read_valid[0]),
        .read_ready_o (bank_read_ready[0]),
        .read_addr_i  (bank_read_addr[0]),
        .read_tag_i   (bank_read_tag[0]),
        .read_valid_o (bank_rvalid[0]),
        .read_tag_o   (bank_rtag[0]),
        .read_data_o  (bank_rdata[0])
    );

    // Odd registers
    register_file_bank #(
        .DualPort(DualPort)
    ) u_bank_odd (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .write_valid_i(bank_write[1].valid),
        .write_mask_i (bank_write[1].mask),
        .write_addr_i (bank_write[1].addr[RegAddrWidth-1:1]),
        .write_data_i (bank_write[1].data),
        .write_ready_o(),
        .read_valid_i (bank_read_valid[1]),
        .read_ready_o (bank_read_ready[1]),
        .read_addr_i  (bank_read_addr[1]),
        .read_tag_i   (bank_read_tag[1]),
        .read_valid_o (bank_rvalid[1]),
        .read_tag_o   (bank_rtag[1]),
        .read_data_o  (bank_rdata[1])
    );

    operand_collector u_collector (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .alloc_i     (alloc),
        .bank_valid_i(bank_rvalid),
        .bank_tag_i  (bank_rtag),
        .bank_data_i (bank_rdata),
        .full_o      (collector_full),
        .pair_o      (pair_o)
    );

endmodule

/* source/register_file_bank.sv */
/*
 * One register bank. Single-port build gives a write priority and refuses
 * the read that cycle. Writes are always accepted.
 */
`timescale 1ns/1ps

module register_file_bank import rf_pkg::*, operand_pkg::*; #(
    parameter bit DualPort = 1'b0
) (
    input  logic         clk_i,
    input  logic         rst_n_i,
    // Write port
    input  logic         write_valid_i,
    input  we_mask_t     write_mask_i,
    input  bank_addr_t   write_addr_i,
    input  warp_data_t   write_data_i,
    output logic         write_ready_o,
    // Read request
    input  logic         read_valid_i,
    output logic         read_ready_o,
    input  bank_addr_t   read_addr_i,
    input  rf_read_tag_t read_tag_i,
    // Read result, one cycle after the accepted read
    output logic         read_valid_o,
    output rf_read_tag_t read_tag_o,
    output warp_data_t   read_data_o
);

    // Memory port signals
    logic       [DualPort:0] mem_req;
    logic       [DualPort:0] mem_we;
    bank_addr_t [DualPort:0] mem_addr;
    warp_data_t [DualPort:0] mem_wdata;
    warp_data_t [DualPort:0] mem_rdata;
    be_t        [DualPort:0] mem_be;

    be_t          write_be;
    logic         read_accept;
    rf_read_tag_t read_tag_q;

    // ####################################################################
    // Port mapping

    // Lane mask to byte enables
    for (genvar l = 0; l < WarpWidth; l++) begin : gen_write_be
        assign write_be[l*BytesPerLane +: BytesPerLane] = {BytesPerLane{write_mask_i[l]}};
    end

    if (DualPort) begin : gen_dual_port
        // Port 0 reads, port 1 writes
        assign mem_req      = {write_valid_i, read_valid_i};
        assign mem_we       = 2'b10;
        assign mem_addr     = {write_addr_i, read_addr_i};
        assign mem_wdata    = {write_data_i, warp_data_t'('0)};
        assign mem_be       = {write_be, be_t'('1)};
        assign read_ready_o = 1'b1;
    end else begin : gen_single_port
        // Shared port, write wins
        assign mem_req[0]   = write_valid_i | read_valid_i;
        assign mem_we[0]    = write_valid_i;
        assign mem_addr[0]  = write_valid_i ? write_addr_i : read_addr_i;
        assign mem_wdata[0] = write_data_i;
        assign mem_be[0]    = write_valid_i ? write_be : '1;
        assign read_ready_o = ~write_valid_i;
    end

    assign write_ready_o = 1'b1;
    assign read_accept   = read_valid_i & read_ready_o;

    // ####################################################################
    // Result alignment

    // Valid and tag follow the memory latency
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            read_valid_o <= 1'b0;
        end else begin
            read_valid_o <= read_accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_accept) begin
            read_tag_q <= read_tag_i;
        end
    end

    assign read_tag_o  = read_tag_q;
    // Read port is always port 0
    assign read_data_o = mem_rdata[0];

    bank_sram #(
        .DualPort(DualPort)
    ) u_bank_sram (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .req_i  (mem_req),
        .we_i   (mem_we),
        .addr_i (mem_addr),
        .wdata_i(mem_wdata),
        .be_i   (mem_be),
        .rdata_o(mem_rdata)
    );

endmodule

/* source/rf_pkg.sv */
/*
 * Register file sizes and shared types. Two banks split by register bit 0,
 * so NumBanks must stay 2. RegisterWidth must be a multiple of 8.
 */
package rf_pkg;

    // Warp and register file geometry
    localparam int unsigned WarpWidth     = 4;
    localparam int unsigned RegisterWidth = 32;
    localparam int unsigned NumRegisters  = 32;
    localparam int unsigned NumBanks      = 2;
    localparam int unsigned BankRegs      = NumRegisters / NumBanks;

    localparam int unsigned RegAddrWidth  = $clog2(NumRegisters);
    localparam int unsigned BankAddrWidth = $clog2(BankRegs);
    localparam int unsigned BytesPerLane  = RegisterWidth / 8;
    localparam int unsigned BeWidth       = WarpWidth * BytesPerLane;

    typedef logic [RegAddrWidth-1:0]  reg_addr_t;
    // Register index with its bank bit dropped
    typedef logic [BankAddrWidth-1:0] bank_addr_t;
    typedef logic [RegisterWidth-1:0] data_t;
    typedef data_t [WarpWidth-1:0]    warp_data_t;
    typedef logic [WarpWidth-1:0]     we_mask_t;
    // Byte enables over one warp-wide word
    typedef logic [BeWidth-1:0]       be_t;

    // One warp-wide write, lane mask per lane
    typedef struct packed {
        logic       valid;
        we_mask_t   mask;
        reg_addr_t  addr;
        warp_data_t data;
    } rf_write_t;

endpackage

/* sources.f */
+incdir+tb
source/rf_pkg.sv
source/operand_pkg.sv
source/bank_sram.sv
source/register_file_bank.sv
source/operand_request_router.sv
source/operand_collector.sv
source/regfile_top.sv
tb/tb_regfile_top.sv

/* tb/tb_regfile_model.svh */
/*
 * Reference register file, LFSR stimulus source and compare tasks.
 * Included inside the testbench module, needs rf_pkg and operand_pkg.
 */
`ifndef TB_REGFILE_MODEL_SVH
`define TB_REGFILE_MODEL_SVH

// Reference contents, all lanes of all registers
warp_data_t  model_rf [NumRegisters];
logic [31:0] lfsr_q      = 32'hceacff13;
int unsigned check_count = 0;
int unsigned error_count = 0;

// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int unsigned nbits);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < nbits; i++) begin
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        bits   = {bits[30:0], fb};
    end
    return bits;
endfunction

function automatic warp_data_t rand_warp();
    warp_data_t w;
    for (int l = 0; l < WarpWidth; l++) begin
        w[l] = data_t'(rand_bits(RegisterWidth));
    end
    return w;
endfunction

task automatic model_clear();
    for (int r = 0; r < NumRegisters; r++) begin
        model_rf[r] = '0;
    end
endtask

// Lanes with a clear mask bit keep their old value
task automatic model_write(input rf_write_t w);
    if (w.valid) begin
        for (int l = 0; l < WarpWidth; l++) begin
            if (w.mask[l]) begin
                model_rf[w.addr][l] = w.data[l];
            end
        end
    end
endtask

// Immediate: 16-bit sign extension, same value in every lane
function automatic warp_data_t expected_operand(input operand_spec_t s);
    warp_data_t v;
    data_t      lane;
    if (s.is_imm) begin
        lane = {{(RegisterWidth-ImmWidth){s.word.imm[ImmWidth-1]}}, s.word.imm};
        for (int l = 0; l < WarpWidth; l++) begin
            v[l] = lane;
        end
    end else begin
        v = model_rf[s.word.rf.idx];
    end
    return v;
endfunction

task automatic check_pair(input string name, input operand_pair_t expected,
                          input operand_pair_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch %s: expected %h actual %h", name, expected, actual);
    end
endtask

task automatic check_ready(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch %s write ready: expected %b actual %b", name, expected, actual);
    end
endtask

`endif

/* tb/tb_regfile_top.sv */
/*
 * Random testbench for the single-port build of regfile_top. Writes skip
 * registers with a read in flight, so each pair equals the model at acceptance.
 */
`timescale 1ns/1ps

module tb_regfile_top import rf_pkg::*, operand_pkg::*; ();

    `include "tb_regfile_model.svh"

    // Requests per test
    localparam int unsigned NumReset      = NumRegisters / 2;
    localparam int unsigned NumMasked     = 40;
    localparam int unsigned NumConflict   = 100;
    localparam int unsigned NumImm        = 60;
    localparam int unsigned NumTraffic    = 200;
    localparam int unsigned NumRequests   = NumReset + NumMasked + NumConflict
                                          + NumImm + NumTraffic;
    localparam int unsigned TimeoutCycles = 8 * NumRequests + 200;
    // Bank read cycle plus the collector output register
    localparam int unsigned MinRegLatency = 2;

    // Expected pair plus what is needed to release its registers
    typedef struct {
        operand_pair_t pair;
        operand_req_t  req;
        int unsigned   accept_cycle;
    } expect_t;

    logic          clk;
    logic          rst_n;
    rf_write_t     write_req;
    logic          write_ready;
    operand_req_t  op_req;
    logic          req_ready;
    operand_pair_t pair;

    expect_t       exp_q [$];
    int unsigned   pending_cnt [NumRegisters];
    int unsigned   cycle_count = 0;
    int unsigned   test_count  = 0;
    int unsigned   test_errors_base;
    instr_id_t     next_id;
    bit            accept_seen;
    string         cur_test;

    regfile_top #(
        .DualPort(1'b0)
    ) u_regfile_top (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .write_i      (write_req),
        .write_ready_o(write_ready),
        .req_i        (op_req),
        .req_ready_o  (req_ready),
        .pair_o       (pair)
    );

    always #10 clk = ~clk;

    // ##################################################################
    // Monitor sampling at the rising edge

    always @(posedge clk) begin : monitor
        expect_t e;
        if (rst_n) begin
            if (write_req.valid) begin
                check_ready(cur_test, 1'b1, write_ready);
            end
            if (pair.valid) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("Error in %s: pair_o pulsed with no request outstanding", cur_test);
                end else begin
                    e = exp_q.pop_front();
                    check_pair(cur_test, e.pair, pair);
                    // Only requests with a register source go through a bank
                    if (!e.req.src_a.is_imm || !e.req.src_b.is_imm) begin
                        check_count++;
                        if (cycle_count - e.accept_cycle < MinRegLatency) begin
                            error_count++;
                            $display("Error in %s: pair %0d came %0d cycles after acceptance",
                                     cur_test, e.pair.instr_id, cycle_count - e.accept_cycle);
                        end
                    end
                    if (!e.req.src_a.is_imm) begin
                        pending_cnt[e.req.src_a.word.rf.idx]--;
                    end
                    if (!e.req.src_b.is_imm) begin
                        pending_cnt[e.req.src_b.word.rf.idx]--;
                    end
                end
            end
            accept_seen = op_req.valid && req_ready;
            if (accept_seen) begin
                // Snapshot before this edge's write, which never hits these registers
                e.pair.valid    = 1'b1;
                e.pair.instr_id = op_req.instr_id;
                e.pair.op_a     = expected_operand(op_req.src_a);
                e.pair.op_b     = expected_operand(op_req.src_b);
                e.req           = op_req;
                e.accept_cycle  = cycle_count;
                exp_q.push_back(e);
                if (!op_req.src_a.is_imm) begin
                    pending_cnt[op_req.src_a.word.rf.idx]++;
                end
                if (!op_req.src_b.is_imm) begin
                    pending_cnt[op_req.src_b.word.rf.idx]++;
                end
            end
            model_write(write_req);
        end
        cycle_count++;
        if (cycle_count >= TimeoutCycles) begin
            $display("Error in %s: timeout after %0d cycles, %0d pairs still missing",
                     cur_test, cycle_count, exp_q.size());
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ##################################################################
    // Stimulus helpers called at a falling edge

    // Pad bits above a register index carry noise
    function automatic operand_spec_t make_src(input bit is_imm, input reg_addr_t idx);
        operand_spec_t s;
        logic [31:0]   noise;
        noise      = rand_bits(ImmWidth);
        s.is_imm   = is_imm;
        s.word.imm = noise[ImmWidth-1:0];
        if (!is_imm) begin
            s.word.rf.idx = idx;
        end
        return s;
    endfunction

    function automatic operand_req_t make_req(input operand_spec_t a, input operand_spec_t b);
        operand_req_t r;
        r.valid    = 1'b1;
        r.instr_id = next_id;
        r.src_a    = a;
        r.src_b    = b;
        next_id++;
        return r;
    endfunction

    function automatic bit reads_reg(input operand_req_t r, input reg_addr_t addr);
        return (!r.src_a.is_imm && r.src_a.word.rf.idx == addr)
            || (!r.src_b.is_imm && r.src_b.word.rf.idx == addr);
    endfunction

    task automatic drive_random_write(input operand_req_t r);
        rf_write_t w;
        w.valid = (rand_bits(2) != 0);
        w.mask  = we_mask_t'(rand_bits(WarpWidth));
        w.addr  = reg_addr_t'(rand_bits(RegAddrWidth));
        w.data  = rand_warp();
        // Stay off registers with a read in flight or about to start
        if (pending_cnt[w.addr] != 0 || reads_reg(r, w.addr)) begin
            w.valid = 1'b0;
        end
        write_req = w;
    endtask

    // Holds the request until the monitor saw it accepted
    task automatic send_request(input operand_req_t r, input bit with_writes);
        op_req = r;
        do begin
            if (with_writes) begin
                drive_random_write(r);
            end else begin
                write_req = '0;
            end
            @(negedge clk);
        end while (!accept_seen);
        op_req    = '0;
        write_req = '0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test(input string name);
        cur_test         = name;
        test_errors_base = error_count;
    endtask

    task automatic finish_test(input int unsigned nreq);
        wait_drain();
        test_count++;
        $display("Test %s done: %0d requests, %0d errors",
                 cur_test, nreq, error_count - test_errors_base);
    endtask

    // ##################################################################
    // Test sequence

    initial begin : stimulus
        operand_spec_t a;
        operand_spec_t b;
        reg_addr_t     ra;
        reg_addr_t     rb;
        bit            ia;
        bit            ib;
        clk       = 1'b0;
        rst_n     = 1'b0;
        write_req = '0;
        op_req    = '0;
        next_id   = '0;
        model_clear();
        for (int r = 0; r < NumRegisters; r++) begin
            pending_cnt[r] = 0;
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // Idle cycles first, then every register pair reads zero
        start_test("reset_zero");
        repeat (4) @(negedge clk);
        for (int k = 0; k < NumReset; k++) begin
            a = make_src(1'b0, reg_addr_t'(2 * k));
            b = make_src(1'b0, reg_addr_t'(2 * k + 1));
            send_request(make_req(a, b), 1'b0);
        end
        finish_test(NumReset);

        // Full-mask fill of the whole file
        for (int r = 0; r < NumRegisters; r++) begin
            write_req = '{valid: 1'b1, mask: '1, addr: reg_addr_t'(r), data: rand_warp()};
            @(negedge clk);
        end
        write_req = '0;

        // Masked write, then read of the same register
        start_test("masked_write");
        for (int i = 0; i < NumMasked; i++) begin
            ra        = reg_addr_t'(rand_bits(RegAddrWidth));
            write_req = '{valid: 1'b1, mask: we_mask_t'(rand_bits(WarpWidth)),
                          addr: ra, data: rand_warp()};
            @(negedge clk);
            rb = reg_addr_t'(rand_bits(RegAddrWidth));
            a  = make_src(1'b0, ra);
            b  = make_src(1'b0, rb);
            send_request(make_req(a, b), 1'b0);
            wait_drain();
        end
        finish_test(NumMasked);

        // Same register, same bank or any pair
        start_test("bank_conflict");
        for (int i = 0; i < NumConflict; i++) begin
            ra = reg_addr_t'(rand_bits(RegAddrWidth));
            case (rand_bits(2))
                0: rb = ra;
                1: rb = {bank_addr_t'(rand_bits(BankAddrWidth)), ra[0]};
                default: rb = reg_addr_t'(rand_bits(RegAddrWidth));
            endcase
            a = make_src(1'b0, ra);
            b = make_src(1'b0, rb);
            send_request(make_req(a, b), 1'b0);
        end
        finish_test(NumConflict);

        // At least one immediate per request
        start_test("immediate");
        for (int i = 0; i < NumImm; i++) begin
            ia = (rand_bits(1) != 0);
            ib = (rand_bits(1) != 0);
            if (!ia && !ib) begin
                ia = 1'b1;
            end
            a = make_src(ia, reg_addr_t'(rand_bits(RegAddrWidth)));
            b = make_src(ib, reg_addr_t'(rand_bits(RegAddrWidth)));
            send_request(make_req(a, b), 1'b0);
        end
        finish_test(NumImm);

        // Back to back with writes in most cycles
        start_test("traffic");
        for (int i = 0; i < NumTraffic; i++) begin
            ia = (rand_bits(3) == 0);
            ib = (rand_bits(3) == 0);
            a  = make_src(ia, reg_addr_t'(rand_bits(RegAddrWidth)));
            b  = make_src(ib, reg_addr_t'(rand_bits(RegAddrWidth)));
            send_request(make_req(a, b), 1'b1);
        end
        finish_test(NumTraffic);

        repeat (4) @(negedge clk);
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
